//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
TOP = icache_tb
FILELIST = sim.f
BUILD_DIR = obj_dir
PASS_MSG = Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)

//--- sim.f
verilog/icache_pkg.sv
verilog/icache_way_ram.sv
verilog/icache_lookup.sv
verilog/icache_word_select.sv
verilog/icache_top.sv
sim/icache_tb_assert.sv
sim/icache_tb.sv

//--- sim/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

	localparam int ATTEMPTS = 2000;
	localparam int CYCLE_LIMIT = ATTEMPTS * 14 + 200;

	logic clk;
	logic rst;
	icache_pkg::fetch_req_t fetch;
	logic busy;
	icache_pkg::fetch_rsp_t rsp;
	logic flush;
	icache_pkg::inval_t inval;
	icache_pkg::mem_req_t mem_req;
	icache_pkg::mem_rsp_t mem_rsp;

	// cache model, per set tags, valid bits and victim pointer
	icache_pkg::tag_t model_tag [icache_pkg::SETS][icache_pkg::WAYS];
	logic model_valid [icache_pkg::SETS][icache_pkg::WAYS];
	logic [1:0] model_victim [icache_pkg::SETS];
	// memory model, version per line address
	int unsigned version [icache_pkg::pc_t];
	// accepted requests still owed a response
	icache_pkg::pc_t exp_pc [$];
	logic exp_hit [$];
	logic miss_pending;
	icache_pkg::pc_t miss_pc;
	logic refill_open;
	icache_pkg::pc_t refill_addr;
	// invalidate strobe of the previous cycle
	logic inval_prev;
	int reply_wait;
	logic [31:0] rng;
	int attempts;
	int cycles;
	int drain;
	int mismatches;
	int failures;

	icache_top dut_i (
		.clk     (clk),
		.rst     (rst),
		.fetch   (fetch),
		.busy    (busy),
		.rsp     (rsp),
		.flush   (flush),
		.inval   (inval),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic icache_pkg::pc_t line_of(input icache_pkg::pc_t pc);
		return {pc[31:4], 4'b0000};
	endfunction

	// 8 sets times 8 tags, any word of the line
	function automatic icache_pkg::pc_t pick_pc(input logic [31:0] r);
		return {icache_pkg::tag_t'(r[5:3] * 13 + 5), icache_pkg::index_t'(r[2:0] * 7 + 2),
			r[7:6], 2'b00};
	endfunction

	function int unsigned get_version(input icache_pkg::pc_t addr);
		return version.exists(addr) ? version[addr] : 0;
	endfunction

	// memory content, fixed hash of line address and version
	function automatic icache_pkg::line_t line_content(input icache_pkg::pc_t addr,
			input int unsigned ver);
		icache_pkg::line_t line;
		logic [31:0] h;
		for (int i = 0; i < 4; i++) begin
			h = addr ^ (ver * 32'h9e3779b9) ^ (32'(i) * 32'h85ebca6b);
			h = h ^ (h >> 15);
			line[i*32 +: 32] = h * 32'h2c1b3c6d;
		end
		return line;
	endfunction

	function icache_pkg::inst_t expected_inst(input icache_pkg::pc_t pc);
		icache_pkg::line_t line;
		line = line_content(line_of(pc), get_version(line_of(pc)));
		return line[pc[3:2]*32 +: 32];
	endfunction

	function logic model_lookup(input icache_pkg::pc_t pc);
		for (int w = 0; w < icache_pkg::WAYS; w++) begin
			if (model_valid[pc[9:4]][w] && model_tag[pc[9:4]][w] == pc[31:10]) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic check_equal(input logic [127:0] got, input logic [127:0] exp,
			input string what);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic end_run();
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		fetch = '0;
		flush = 1'b0;
		inval = '0;
		mem_rsp = '0;
		rng = 32'h00b08e58;
		{attempts, cycles, drain, mismatches, failures} = '0;
		{miss_pending, refill_open, reply_wait} = '0;
		inval_prev = 1'b0;
		for (int s = 0; s < icache_pkg::SETS; s++) begin
			model_victim[s] = '0;
			for (int w = 0; w < icache_pkg::WAYS; w++) begin
				model_valid[s][w] = 1'b0;
			end
		end
		repeat (5) @(posedge clk);
		rst <= 1'b0;
	end

	always @(posedge clk) begin
		logic accept;
		logic hit;
		logic quiet;
		logic busy_exp;
		icache_pkg::pc_t p;
		icache_pkg::pc_t a;
		if (!rst) begin
			cycles++;
			// busy follows the model miss, refill and invalidate state
			busy_exp = miss_pending || refill_open || inval.valid || inval_prev;
			check_equal(128'(busy), 128'(busy_exp), "busy");
			// responses come back in acceptance order
			if (rsp.valid) begin
				if (exp_pc.size() == 0) begin
					failures++;
					$display("response for pc %h arrived with no request owed", rsp.pc);
				end else begin
					p = exp_pc.pop_front();
					hit = exp_hit.pop_front();
					check_equal(128'(rsp.pc), 128'(p), "response pc");
					check_equal(128'(rsp.hit), 128'(hit), "response hit flag");
					check_equal(128'(rsp.inst), 128'(expected_inst(p)), "response inst");
				end
			end
			// memory responder, one reply per line request
			if (mem_req.valid) begin
				if (refill_open) begin
					failures++;
					$display("second line request before the reply to the first");
				end else begin
					if (!miss_pending) begin
						failures++;
						$display("line request %h without a predicted miss", mem_req.addr);
					end else begin
						check_equal(128'(mem_req.addr), 128'(line_of(miss_pc)), "line address");
					end
					refill_open = 1'b1;
					refill_addr = mem_req.addr;
					rng = xorshift32(rng);
					reply_wait = 1 + int'(rng[2:0]);
					miss_pending = 1'b0;
				end
			end
			// install into the victim way, then rotate
			if (mem_rsp.valid) begin
				model_tag[refill_addr[9:4]][model_victim[refill_addr[9:4]]] = refill_addr[31:10];
				model_valid[refill_addr[9:4]][model_victim[refill_addr[9:4]]] = 1'b1;
				model_victim[refill_addr[9:4]] = model_victim[refill_addr[9:4]] + 2'd1;
				refill_open = 1'b0;
			end
			if (flush) begin
				exp_pc.delete();
				exp_hit.delete();
			end
			accept = fetch.valid && !busy_exp && !flush;
			if (accept) begin
				hit = model_lookup(fetch.pc);
				exp_pc.push_back(fetch.pc);
				exp_hit.push_back(hit);
				if (!hit) begin
					miss_pending = 1'b1;
					miss_pc = fetch.pc;
				end
			end
			if (inval.valid) begin
				for (int w = 0; w < icache_pkg::WAYS; w++) begin
					if (model_tag[inval.addr[9:4]][w] == inval.addr[31:10]) begin
						model_valid[inval.addr[9:4]][w] = 1'b0;
					end
				end
			end
			inval_prev = inval.valid;
			// next inputs
			mem_rsp <= '0;
			if (refill_open && reply_wait == 1) begin
				mem_rsp <= {1'b1, line_content(refill_addr, get_version(refill_addr))};
			end
			if (reply_wait > 0) begin
				reply_wait--;
			end
			inval <= '0;
			rng = xorshift32(rng);
			flush <= (rng[9:5] == 5'd0);
			quiet = exp_pc.size() == 0 && !miss_pending && !refill_open && !inval.valid;
			// a request that was not taken is held
			if (accept || !fetch.valid) begin
				fetch.valid <= 1'b0;
				if (attempts < ATTEMPTS) begin
					if (rng[4:0] == 5'd0 && quiet && !accept) begin
						// new memory data for a line, then drop it from the cache
						rng = xorshift32(rng);
						a = line_of(pick_pc(rng));
						version[a] = get_version(a) + 1;
						inval <= {1'b1, a};
					end else if (rng[4:0] > 5'd3) begin
						rng = xorshift32(rng);
						fetch <= {1'b1, pick_pc(rng)};
						attempts++;
					end
				end
			end
			if (attempts >= ATTEMPTS && (accept || !fetch.valid) && quiet) begin
				drain++;
			end else begin
				drain = 0;
			end
			if (cycles >= CYCLE_LIMIT) begin
				failures++;
				$display("timeout after %0d cycles with %0d fetches issued", cycles, attempts);
				end_run();
			end else if (drain >= 10) begin
				end_run();
			end
		end
	end

endmodule

//--- sim/icache_tb_assert.sv
`timescale 1ns/1ps

// protocol rules on the icache ports
module icache_tb_assert (
	input logic clk,
	input logic rst,
	input logic flush,
	input logic busy,
	input logic rsp_valid,
	input logic mem_req_valid,
	input logic mem_rsp_valid
);

	// a line request is out and its reply has not come back
	logic refill_open;

	always_ff @(posedge clk) begin
		if (rst || mem_rsp_valid) begin
			refill_open <= 1'b0;
		end else if (mem_req_valid) begin
			refill_open <= 1'b1;
		end
	end

	// single-cycle line request
	a_req_pulse: assert property (@(posedge clk) disable iff (rst)
		mem_req_valid |=> !mem_req_valid)
		else $error("mem_req.valid held for two cycles");

	// flush kills the response due next cycle
	a_flush_quiet: assert property (@(posedge clk) disable iff (rst)
		flush |=> !rsp_valid)
		else $error("rsp.valid high in the cycle after flush");

	// fetches held off for the whole refill
	a_busy_refill: assert property (@(posedge clk) disable iff (rst)
		(mem_req_valid || refill_open) |-> busy)
		else $error("busy low while a refill is open");

	a_reset_quiet: assert property (@(posedge clk)
		rst |=> (!rsp_valid && !mem_req_valid && !busy))
		else $error("outputs not low after reset");

endmodule

bind icache_top icache_tb_assert assert_i (
	.clk           (clk),
	.rst           (rst),
	.flush         (flush),
	.busy          (busy),
	.rsp_valid     (rsp.valid),
	.mem_req_valid (mem_req.valid),
	.mem_rsp_valid (mem_rsp.valid)
);

//--- verilog/icache_lookup.sv
`timescale 1ns/1ps

// front half of the icache
// accepts fetches, compares tags, runs the single refill and the invalidate
module icache_lookup (
	input  logic                                   clk,
	input  logic                                   rst,
	input  icache_pkg::fetch_req_t                 fetch,
	input  logic                                   flush,
	input  icache_pkg::inval_t                     inval,
	input  icache_pkg::mem_rsp_t                   mem_rsp,
	input  icache_pkg::tag_t [icache_pkg::WAYS-1:0] tag_rd,
	output logic                                   busy,
	output icache_pkg::mem_req_t                   mem_req,
	output logic                                   ram_en,
	output icache_pkg::way_t                       ram_we,
	output icache_pkg::index_t                     ram_index,
	output icache_pkg::tag_t                       tag_wdata,
	output icache_pkg::line_t                      line_wdata,
	output icache_pkg::lookup_t                    sel
);

	typedef enum logic [1:0] {
		REFILL_IDLE,
		REFILL_REQ,
		REFILL_WAIT
	} refill_state_t;

	// address field helpers
	function automatic icache_pkg::tag_t pc_tag(input icache_pkg::pc_t pc);
		return pc[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
	endfunction

	function automatic icache_pkg::index_t pc_index(input icache_pkg::pc_t pc);
		return pc[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
	endfunction

	// compare stage request
	icache_pkg::fetch_req_t req_q;
	// valid bits and round-robin victim, per set
	icache_pkg::way_t valid_q [icache_pkg::SETS];
	logic [$clog2(icache_pkg::WAYS)-1:0] victim_q [icache_pkg::SETS];
	// refill control
	refill_state_t state_q;
	icache_pkg::pc_t miss_pc_q;
	// refill still installs but owes no response
	logic drop_q;
	// invalidate waits one cycle for its tag read
	logic inval_valid_q;
	icache_pkg::index_t inval_index_q;
	icache_pkg::tag_t inval_tag_q;

	logic accept;
	icache_pkg::index_t req_index;
	icache_pkg::way_t hit_way;
	logic cmp_hit;
	logic cmp_miss;
	icache_pkg::index_t miss_index;
	icache_pkg::way_t victim_way;
	logic refill_done;

	// take a fetch only when nothing holds us off
	assign accept = fetch.valid && !busy && !flush;

	// tag compare on the registered request
	assign req_index = pc_index(req_q.pc);

	always_comb begin
		for (int w = 0; w < icache_pkg::WAYS; w++) begin
			hit_way[w] = valid_q[req_index][w] && (tag_rd[w] == pc_tag(req_q.pc));
		end
	end

	assign cmp_hit = req_q.valid && (hit_way != '0);
	assign cmp_miss = req_q.valid && (hit_way == '0);

	// refill target is the set's round-robin way
	assign miss_index = pc_index(miss_pc_q);
	assign victim_way = icache_pkg::way_t'(1) << victim_q[miss_index];
	// memory answers only while waiting, one reply per request
	assign refill_done = (state_q == REFILL_WAIT) && mem_rsp.valid;

	// miss in compare, any refill, or an invalidate in its two cycles
	assign busy = cmp_miss || (state_q != REFILL_IDLE) || inval.valid || inval_valid_q;

	// line request, a single cycle after the miss
	assign mem_req.valid = (state_q == REFILL_REQ);
	assign mem_req.addr = {miss_pc_q[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W],
		{icache_pkg::OFFSET_W{1'b0}}};

	// ram port, refill write first, then invalidate read, then fetch read
	assign ram_en = accept || inval.valid;
	assign ram_we = refill_done ? victim_way : '0;
	assign tag_wdata = pc_tag(miss_pc_q);
	assign line_wdata = mem_rsp.line;

	always_comb begin
		if (refill_done) begin
			ram_index = miss_index;
		end else if (inval.valid) begin
			ram_index = pc_index(inval.addr);
		end else begin
			ram_index = pc_index(fetch.pc);
		end
	end

	// handoff to the word selector
	// flush in this cycle kills the response due next cycle
	always_comb begin
		sel = '0;
		if (refill_done) begin
			sel.valid = !drop_q && !flush;
			sel.hit = 1'b0;
			sel.way = victim_way;
			sel.pc = miss_pc_q;
			sel.line = mem_rsp.line;
		end else begin
			sel.valid = cmp_hit && !flush;
			sel.hit = cmp_hit;
			sel.way = hit_way;
			sel.pc = req_q.pc;
		end
	end

	// compare stage register, pc only moves on accept
	always_ff @(posedge clk) begin
		if (rst) begin
			req_q.valid <= 1'b0;
		end else begin
			req_q.valid <= accept;
		end
		if (accept) begin
			req_q.pc <= fetch.pc;
		end
	end

	// refill fsm
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= REFILL_IDLE;
			drop_q <= 1'b0;
		end else begin
			case (state_q)
				REFILL_IDLE: begin
					if (cmp_miss) begin
						state_q <= REFILL_REQ;
						// miss seen in a flush cycle still refills
						drop_q <= flush;
					end
				end
				REFILL_REQ: begin
					state_q <= REFILL_WAIT;
					if (flush) begin
						drop_q <= 1'b1;
					end
				end
				REFILL_WAIT: begin
					if (flush) begin
						drop_q <= 1'b1;
					end
					if (mem_rsp.valid) begin
						state_q <= REFILL_IDLE;
					end
				end
				default: begin
					state_q <= REFILL_IDLE;
				end
			endcase
		end
		if (state_q == REFILL_IDLE && cmp_miss) begin
			miss_pc_q <= req_q.pc;
		end
	end

	// valid bits, victim pointers and the invalidate pipeline
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < icache_pkg::SETS; s++) begin
				valid_q[s] <= '0;
				victim_q[s] <= '0;
			end
			inval_valid_q <= 1'b0;
		end else begin
			inval_valid_q <= inval.valid;
			// install marks the victim valid and moves the pointer on
			if (refill_done) begin
				valid_q[miss_index] <= valid_q[miss_index] | victim_way;
				victim_q[miss_index] <= victim_q[miss_index] + 1'b1;
			end
			// tag_rd now holds the invalidate set's tags
			if (inval_valid_q) begin
				for (int w = 0; w < icache_pkg::WAYS; w++) begin
					if (tag_rd[w] == inval_tag_q) begin
						valid_q[inval_index_q][w] <= 1'b0;
					end
				end
			end
		end
		if (inval.valid) begin
			inval_index_q <= pc_index(inval.addr);
			inval_tag_q <= pc_tag(inval.addr);
		end
	end

endmodule

//--- verilog/icache_pkg.sv
package icache_pkg;

	// cache geometry
	localparam int ADDR_W = 32;
	localparam int INST_W = 32;
	localparam int LINE_W = 128;
	localparam int WAYS = 4;
	localparam int SETS = 64;

	// address split is tag, index, offset from msb to lsb
	localparam int OFFSET_W = 4;
	localparam int INDEX_W = 6;
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
	// upper offset bits pick the instruction inside a line
	localparam int WORD_SEL_W = 2;

	typedef logic [ADDR_W-1:0] pc_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [LINE_W-1:0] line_t;
	typedef logic [INST_W-1:0] inst_t;
	// one bit per way, one-hot when it names a single way
	typedef logic [WAYS-1:0] way_t;

	// fetch port, strobe plus address
	typedef struct packed {
		logic valid;
		pc_t pc;
	} fetch_req_t;

	// fetch response, hit clear means the word came from a refill
	typedef struct packed {
		logic valid;
		logic hit;
		pc_t pc;
		inst_t inst;
	} fetch_rsp_t;

	// invalidate strobe for any line holding this address
	typedef struct packed {
		logic valid;
		pc_t addr;
	} inval_t;

	// line request to memory, offset bits of addr are zero
	typedef struct packed {
		logic valid;
		pc_t addr;
	} mem_req_t;

	// full line reply from memory
	typedef struct packed {
		logic valid;
		line_t line;
	} mem_rsp_t;

	// lookup to word selector handoff
	typedef struct packed {
		logic valid;
		logic hit;
		way_t way;
		pc_t pc;
		line_t line;
	} lookup_t;

endpackage

//--- verilog/icache_top.sv
`timescale 1ns/1ps

// four-way instruction cache, 64 sets of 16-byte lines
module icache_top (
	input  logic                   clk,
	input  logic                   rst,
	input  icache_pkg::fetch_req_t fetch,
	output logic                   busy,
	output icache_pkg::fetch_rsp_t rsp,
	input  logic                   flush,
	input  icache_pkg::inval_t     inval,
	output icache_pkg::mem_req_t   mem_req,
	input  icache_pkg::mem_rsp_t   mem_rsp
);

	// shared ram controls from the lookup
	logic ram_en;
	icache_pkg::way_t ram_we;
	icache_pkg::index_t ram_index;
	icache_pkg::tag_t tag_wdata;
	icache_pkg::line_t line_wdata;

	// per-way read data
	icache_pkg::tag_t [icache_pkg::WAYS-1:0] tag_rd;
	icache_pkg::line_t [icache_pkg::WAYS-1:0] line_rd;

	// compare or refill result toward the word selector
	icache_pkg::lookup_t sel;

	icache_lookup lookup_i (
		.clk        (clk),
		.rst        (rst),
		.fetch      (fetch),
		.flush      (flush),
		.inval      (inval),
		.mem_rsp    (mem_rsp),
		.tag_rd     (tag_rd),
		.busy       (busy),
		.mem_req    (mem_req),
		.ram_en     (ram_en),
		.ram_we     (ram_we),
		.ram_index  (ram_index),
		.tag_wdata  (tag_wdata),
		.line_wdata (line_wdata),
		.sel        (sel)
	);

	// tag arrays, read back by the lookup
	for (genvar w = 0; w < icache_pkg::WAYS; w++) begin : g_tag_way
		icache_way_ram #(
			.payload_t (icache_pkg::tag_t),
			.DEPTH     (icache_pkg::SETS)
		) tag_ram_i (
			.clk   (clk),
			.en    (ram_en),
			.we    (ram_we[w]),
			.index (ram_index),
			.wdata (tag_wdata),
			.rdata (tag_rd[w])
		);
	end

	// line arrays, read back by the word selector
	for (genvar w = 0; w < icache_pkg::WAYS; w++) begin : g_data_way
		icache_way_ram #(
			.payload_t (icache_pkg::line_t),
			.DEPTH     (icache_pkg::SETS)
		) data_ram_i (
			.clk   (clk),
			.en    (ram_en),
			.we    (ram_we[w]),
			.index (ram_index),
			.wdata (line_wdata),
			.rdata (line_rd[w])
		);
	end

	icache_word_select word_select_i (
		.clk     (clk),
		.rst     (rst),
		.sel     (sel),
		.line_rd (line_rd),
		.rsp     (rsp)
	);

endmodule

//--- verilog/icache_way_ram.sv
`timescale 1ns/1ps

// one way of the cache
// used for the tag array and the line array alike
module icache_way_ram #(
	parameter type payload_t = icache_pkg::tag_t,
	parameter int DEPTH = icache_pkg::SETS
) (
	input  logic               clk,
	input  logic               en,
	input  logic               we,
	input  icache_pkg::index_t index,
	input  payload_t           wdata,
	output payload_t           rdata
);

	// storage, contents undefined until written
	payload_t mem [DEPTH];

	// single port
	// write wins over read when both are asked for
	// rdata keeps the last read while en is low, so a stalled
	// compare stage still sees the tags and lines it fetched
	always_ff @(posedge clk) begin
		if (we) begin
			mem[index] <= wdata;
		end else if (en) begin
			rdata <= mem[index];
		end
	end

endmodule

//--- verilog/icache_word_select.sv
`timescale 1ns/1ps

// back half of the icache
// picks the line, extracts the instruction and registers the response
module icache_word_select (
	input  logic                                    clk,
	input  logic                                    rst,
	input  icache_pkg::lookup_t                     sel,
	input  icache_pkg::line_t [icache_pkg::WAYS-1:0] line_rd,
	output icache_pkg::fetch_rsp_t                  rsp
);

	// line read from the hit way
	icache_pkg::line_t way_line;
	// hit line or refill line
	icache_pkg::line_t line;
	// same line seen as instructions, word 0 in the low bits
	icache_pkg::inst_t [2**icache_pkg::WORD_SEL_W-1:0] words;
	logic [icache_pkg::WORD_SEL_W-1:0] word_sel;

	// sel.way is one-hot on a hit, so an or of the masked lines is a mux
	always_comb begin
		way_line = '0;
		for (int w = 0; w < icache_pkg::WAYS; w++) begin
			if (sel.way[w]) begin
				way_line = way_line | line_rd[w];
			end
		end
	end

	// a miss carries its line straight from the memory reply
	assign line = sel.hit ? way_line : sel.line;
	assign words = line;

	// pc bits 3:2
	assign word_sel = sel.pc[icache_pkg::OFFSET_W-1 -: icache_pkg::WORD_SEL_W];

	// response register, one cycle after compare or refill
	always_ff @(posedge clk) begin
		if (rst) begin
			rsp <= '0;
		end else begin
			rsp.valid <= sel.valid;
			rsp.hit <= sel.hit;
			rsp.pc <= sel.pc;
			rsp.inst <= words[word_sel];
		end
	end

endmodule
